// File: vlog.f
+incdir+logic
logic/tpu_ctrl_pkg.sv
logic/tpu_data_pkg.sv
logic/systolic_mac_array.sv
logic/accumulator_control_unit.sv
logic/accumulator_bank.sv
logic/tpu_slice_top.sv
dv/tpu_checker.sv
dv/tpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tpu_tb
LOG       ?= sim.log
SEED_ARGS ?=
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation into $(LOG) and check the result"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP LOG SEED_ARGS OBJ_DIR VFLAGS"
	@echo "  example: make test SEED_ARGS=-GSEED=12345"

test:
	$(VERILATOR) $(VFLAGS) $(SEED_ARGS) -f vlog.f --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tpu_tb.sv
`timescale 1ns/1ps
`include "tpu_cfg.svh"

module tpu_tb #(
    parameter logic [31:0] SEED = 32'h7d3b_6165
);

    localparam int M          = `MUL_SIZE;
    localparam int MAX_N      = `ACC_DEPTH - `MUL_SIZE + 1;
    localparam int NUM_RANDOM = 4;
    localparam int NUM_PASSES = NUM_RANDOM + 3;   // clear pass and two accumulate passes
    // every pass is followed by a full readout of up to two cycles per row
    localparam int WATCHDOG_CYCLES =
        2 * (NUM_PASSES * (`ACC_DEPTH + 4 * M) + NUM_PASSES * (2 * `ACC_DEPTH + 2) + 16);

    logic                    clk, rst_n, weight_we, start, act_valid, rd_en, rd_valid, busy, done;
    logic [`CNT_W-1:0]       weight_row, vec_count, rd_addr;
    tpu_data_pkg::act_vec_t  weight_data, act;
    tpu_ctrl_pkg::mac_mode_e mode;
    tpu_data_pkg::psum_vec_t rd_data;
    logic [31:0]             lfsr_q;
    int                      checks, errors;

    tpu_slice_top dut0 (
        .clk_i(clk), .rst_n_i(rst_n), .weight_we_i(weight_we), .weight_row_i(weight_row),
        .weight_data_i(weight_data), .start_i(start), .vec_count_i(vec_count), .mode_i(mode),
        .act_valid_i(act_valid), .act_i(act), .rd_en_i(rd_en), .rd_addr_i(rd_addr),
        .rd_data_o(rd_data), .rd_valid_o(rd_valid), .busy_o(busy), .done_o(done)
    );

    tpu_checker chk0 (
        .clk_i(clk), .rst_n_i(rst_n), .weight_we_i(weight_we), .weight_row_i(weight_row),
        .weight_data_i(weight_data), .start_i(start), .vec_count_i(vec_count), .mode_i(mode),
        .act_valid_i(act_valid), .act_i(act), .rd_en_i(rd_en), .rd_addr_i(rd_addr),
        .rd_data_i(rd_data), .rd_valid_i(rd_valid), .busy_i(busy), .done_i(done),
        .cmd_i(dut0.acc_cmd), .psum_i(dut0.psum), .check_cnt_o(checks), .err_cnt_o(errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v[b] = lfsr_q[0];
        end
    endtask

    task automatic random_vec(output tpu_data_pkg::act_vec_t v);
        logic [31:0] r;
        for (int i = 0; i < M; i++) begin
            draw_bits(`ACT_W, r);
            v[i] = r[`ACT_W-1:0];
        end
    endtask

    task automatic load_weights();
        tpu_data_pkg::act_vec_t v;
        for (int r = 0; r < M; r++) begin
            random_vec(v);
            @(posedge clk);
            weight_we <= 1'b1;
            weight_row <= `CNT_W'(r);
            weight_data <= v;
        end
        @(posedge clk);
        weight_we <= 1'b0;
    endtask

    // poke sends a start and a weight write while the pass is busy, both must be dropped
    task automatic run_pass(input int n, input tpu_ctrl_pkg::mac_mode_e m, input bit zero_acts,
                            input bit poke);
        tpu_data_pkg::act_vec_t v;
        logic [31:0]            r;
        @(posedge clk);
        while (busy) @(posedge clk);
        start <= 1'b1;
        vec_count <= `CNT_W'(n);
        mode <= m;
        for (int k = 0; k < n; k++) begin
            if (zero_acts) begin
                v = '0;
            end else begin
                random_vec(v);
            end
            @(posedge clk);
            start <= 1'b0;
            act_valid <= 1'b1;
            act <= v;
        end
        @(posedge clk);
        act_valid <= 1'b0;
        act <= '0;
        if (poke) begin
            draw_bits(`CNT_W, r);
            random_vec(v);
            @(posedge clk);
            start <= 1'b1;
            vec_count <= r[`CNT_W-1:0];
            mode <= (m == tpu_ctrl_pkg::MODE_OVERWRITE) ? tpu_ctrl_pkg::MODE_ACCUMULATE
                                                        : tpu_ctrl_pkg::MODE_OVERWRITE;
            weight_we <= 1'b1;
            weight_row <= '0;
            weight_data <= v;
            @(posedge clk);
            start <= 1'b0;
            weight_we <= 1'b0;
        end
        do @(posedge clk); while (!done);
    endtask

    task automatic read_rows();
        logic [31:0] r;
        for (int a = 0; a < `ACC_DEPTH; a++) begin
            draw_bits(1, r);
            if (r[0]) begin
                @(posedge clk);
                rd_en <= 1'b0;   // idle gap between reads
            end
            @(posedge clk);
            rd_en <= 1'b1;
            rd_addr <= `CNT_W'(a);
        end
        @(posedge clk);
        rd_en <= 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        int          n;
        lfsr_q = SEED;
        rst_n = 1'b0;
        weight_we = 1'b0;
        weight_row = '0;
        weight_data = '0;
        start = 1'b0;
        vec_count = '0;
        mode = tpu_ctrl_pkg::MODE_OVERWRITE;
        act_valid = 1'b0;
        act = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        load_weights();
        run_pass(MAX_N, tpu_ctrl_pkg::MODE_OVERWRITE, 1'b1, 1'b0);   // clears every row
        read_rows();
        n = MAX_N;
        for (int p = 0; p < NUM_RANDOM; p++) begin
            load_weights();
            draw_bits(6, r);
            n = 1 + int'(r % MAX_N);
            run_pass(n, tpu_ctrl_pkg::MODE_OVERWRITE, 1'b0, p == 1);
            read_rows();
        end
        run_pass(n, tpu_ctrl_pkg::MODE_ACCUMULATE, 1'b0, 1'b0);
        read_rows();
        load_weights();
        run_pass(n, tpu_ctrl_pkg::MODE_ACCUMULATE, 1'b0, 1'b1);
        read_rows();

        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: dv/tpu_checker.sv
`timescale 1ns/1ps
`include "tpu_cfg.svh"

module tpu_checker (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    weight_we_i,
    input  logic [`CNT_W-1:0]       weight_row_i,
    input  tpu_data_pkg::act_vec_t  weight_data_i,
    input  logic                    start_i,
    input  logic [`CNT_W-1:0]       vec_count_i,
    input  tpu_ctrl_pkg::mac_mode_e mode_i,
    input  logic                    act_valid_i,
    input  tpu_data_pkg::act_vec_t  act_i,
    input  logic                    rd_en_i,
    input  logic [`CNT_W-1:0]       rd_addr_i,
    input  tpu_data_pkg::psum_vec_t rd_data_i,
    input  logic                    rd_valid_i,
    input  logic                    busy_i,
    input  logic                    done_i,
    input  tpu_ctrl_pkg::acc_cmd_t  cmd_i,
    input  tpu_data_pkg::psum_vec_t psum_i,
    output int                      check_cnt_o,
    output int                      err_cnt_o
);

    localparam int M = `MUL_SIZE;

    logic signed [`ACT_W-1:0] w_m   [M][M];          // w_m[i][j] is weight row i, column j
    tpu_data_pkg::psum_vec_t  acc_m [`ACC_DEPTH];
    logic [M-1:0]             known_m [`ACC_DEPTH];  // lanes that some pass has written
    tpu_data_pkg::act_vec_t   vec_m [`ACC_DEPTH];    // vectors of the running pass
    tpu_data_pkg::psum_vec_t  rd_exp;
    logic [M-1:0]             rd_known;
    logic                     busy_m, in_pass, wait_first, prev_rd_en, add_m;
    int                       n_m, c0, cyc, rd_row;
    int                       checks = 0;
    int                       errors = 0;

    assign check_cnt_o = checks;
    assign err_cnt_o   = errors;

    function automatic logic signed [`ACC_W-1:0] lane_dot(input tpu_data_pkg::act_vec_t v,
                                                          input int j);
        int sum;
        sum = 0;
        for (int i = 0; i < M; i++) begin
            sum += int'(v[i]) * int'(w_m[i][j]);
        end
        return `ACC_W'(sum);
    endfunction

    task automatic check_value(input string name, input logic signed [31:0] exp_v,
                               input logic signed [31:0] got_v);
        checks++;
        if (got_v !== exp_v) begin
            errors++;
            $display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp_v, got_v);
        end
    endtask

    always @(posedge clk_i) begin
        int                       a;
        logic                     busy_next, done_exp;
        logic [M-1:0]             exp_mask;
        logic signed [`ACC_W-1:0] exp_lane;
        if (!rst_n_i) begin
            busy_m = 1'b0;
            in_pass = 1'b0;
            wait_first = 1'b0;
            prev_rd_en = 1'b0;
            cyc = 0;
            for (int r = 0; r < `ACC_DEPTH; r++) begin
                known_m[r] = '0;
            end
        end else begin
            cyc++;
            busy_next = busy_m;
            check_value("busy_o", busy_m, busy_i);
            done_exp = in_pass && !wait_first && cyc == c0 + 2 * M + n_m - 1;
            check_value("done_o", done_exp, done_i);
            if (done_exp) begin
                in_pass = 1'b0;
                busy_next = 1'b0;   // busy still shows on the done cycle
            end

            check_value("rd_valid_o", prev_rd_en, rd_valid_i);
            for (int j = 0; j < M; j++) begin
                if (prev_rd_en && rd_known[j]) begin
                    check_value($sformatf("rd_data_o[%0d] row %0d", j, rd_row), rd_exp[j],
                                rd_data_i[j]);
                end
            end
            prev_rd_en = rd_en_i;
            if (rd_en_i) begin
                rd_row   = int'(rd_addr_i);
                rd_exp   = acc_m[rd_row];   // a write on this edge is not seen yet
                rd_known = known_m[rd_row];
            end

            // row a leaves the array MUL_SIZE+a cycles after the first vector
            a = cyc - c0 - M;
            if (in_pass && !wait_first && a >= 0 && a <= n_m + M - 2) begin
                for (int j = 0; j < M; j++) begin
                    exp_mask[j] = (a - j >= 0) && (a - j < n_m);
                end
                check_value("cmd.wr", 1, cmd_i.wr);
                check_value("cmd.add", add_m, cmd_i.add);
                check_value("cmd.addr", a, cmd_i.addr);
                check_value("cmd.mask", exp_mask, cmd_i.mask);
                for (int j = 0; j < M; j++) begin
                    if (exp_mask[j]) begin
                        exp_lane = lane_dot(vec_m[a-j], j);
                        check_value($sformatf("psum_o[%0d] row %0d", j, a), exp_lane, psum_i[j]);
                        if (add_m) begin
                            acc_m[a][j] = acc_m[a][j] + exp_lane;   // wraps at ACC_W
                        end else begin
                            acc_m[a][j] = exp_lane;
                            known_m[a][j] = 1'b1;
                        end
                    end
                end
            end else begin
                check_value("cmd.wr", 0, cmd_i.wr);
            end

            if (weight_we_i && !busy_m && weight_row_i < `CNT_W'(M)) begin
                for (int j = 0; j < M; j++) begin
                    w_m[weight_row_i][j] = weight_data_i[j];
                end
            end
            if (act_valid_i && in_pass) begin
                if (wait_first) begin
                    c0 = cyc;
                    wait_first = 1'b0;
                end
                if (cyc - c0 < `ACC_DEPTH) begin
                    vec_m[cyc-c0] = act_i;
                end
            end
            if (start_i && !busy_m) begin
                in_pass = 1'b1;
                wait_first = 1'b1;
                n_m = int'(vec_count_i);
                add_m = (mode_i == tpu_ctrl_pkg::MODE_ACCUMULATE);
                busy_next = 1'b1;
            end
            busy_m = busy_next;
        end
    end

endmodule

// File: logic/tpu_slice_top.sv
`timescale 1ns/1ps
`include "tpu_cfg.svh"

module tpu_slice_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    weight_we_i,
    input  logic [`CNT_W-1:0]       weight_row_i,
    input  tpu_data_pkg::act_vec_t  weight_data_i,
    input  logic                    start_i,
    input  logic [`CNT_W-1:0]       vec_count_i,
    input  tpu_ctrl_pkg::mac_mode_e mode_i,
    input  logic                    act_valid_i,
    input  tpu_data_pkg::act_vec_t  act_i,
    input  logic                    rd_en_i,
    input  logic [`CNT_W-1:0]       rd_addr_i,
    output tpu_data_pkg::psum_vec_t rd_data_o,
    output logic                    rd_valid_o,
    output logic                    busy_o,
    output logic                    done_o
);

    tpu_ctrl_pkg::acc_cmd_t  acc_cmd;
    tpu_data_pkg::psum_vec_t psum;
    logic                    weight_we;

    // the tile stays fixed while a pass is in flight
    assign weight_we = weight_we_i & ~busy_o;

    systolic_mac_array u_mac (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .act_valid_i   (act_valid_i),
        .act_i         (act_i),
        .weight_we_i   (weight_we),
        .weight_row_i  (weight_row_i),
        .weight_data_i (weight_data_i),
        .psum_o        (psum)
    );

    accumulator_control_unit u_acc_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (start_i),
        .vec_count_i (vec_count_i),
        .mode_i      (mode_i),
        .act_valid_i (act_valid_i),
        .cmd_o       (acc_cmd),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    accumulator_bank u_acc_bank (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .cmd_i      (acc_cmd),
        .psum_i     (psum),
        .rd_en_i    (rd_en_i),
        .rd_addr_i  (rd_addr_i),
        .rd_data_o  (rd_data_o),
        .rd_valid_o (rd_valid_o)
    );

endmodule

// File: logic/accumulator_bank.sv
`timescale 1ns/1ps
`include "tpu_cfg.svh"

module accumulator_bank (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  tpu_ctrl_pkg::acc_cmd_t  cmd_i,
    input  tpu_data_pkg::psum_vec_t psum_i,
    input  logic                    rd_en_i,
    input  logic [`CNT_W-1:0]       rd_addr_i,
    output tpu_data_pkg::psum_vec_t rd_data_o,
    output logic                    rd_valid_o
);

    localparam int ADDR_W = $clog2(`ACC_DEPTH);

    tpu_data_pkg::psum_vec_t mem_q [`ACC_DEPTH];
    tpu_data_pkg::psum_vec_t wr_row;    // addressed row after the masked update
    logic [ADDR_W-1:0]       wr_idx;
    logic [ADDR_W-1:0]       rd_idx;

    assign wr_idx = cmd_i.addr[ADDR_W-1:0];
    assign rd_idx = rd_addr_i[ADDR_W-1:0];

    // read-modify-write of one row, lanes outside the mask keep what they had
    always_comb begin
        wr_row = mem_q[wr_idx];
        for (int j = 0; j < `MUL_SIZE; j++) begin
            if (cmd_i.mask[j]) begin
                wr_row[j] = cmd_i.add ? wr_row[j] + psum_i[j] : psum_i[j];  // wraps at ACC_W
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_i.wr) begin
            mem_q[wr_idx] <= wr_row;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_idx];   // a write on the same edge is seen one read later
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

    // the controller must keep its row counter inside the bank
    a_wr_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cmd_i.wr |-> cmd_i.addr < `CNT_W'(`ACC_DEPTH));

endmodule

// File: logic/accumulator_control_unit.sv
`timescale 1ns/1ps
`include "tpu_cfg.svh"

module accumulator_control_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    start_i,
    input  logic [`CNT_W-1:0]       vec_count_i,
    input  tpu_ctrl_pkg::mac_mode_e mode_i,
    input  logic                    act_valid_i,
    output tpu_ctrl_pkg::acc_cmd_t  cmd_o,
    output logic                    busy_o,
    output logic                    done_o
);

    tpu_ctrl_pkg::acc_state_e state_q;
    tpu_ctrl_pkg::acc_state_e next_state;
    tpu_ctrl_pkg::mac_mode_e  mode_q;
    tpu_ctrl_pkg::acc_cmd_t   cmd_q;
    tpu_ctrl_pkg::acc_cmd_t   row_cmd;      // command for the row under the counter
    logic [`CNT_W-1:0]        n_q;
    logic [`CNT_W-1:0]        cnt_q;        // fill latency first, then the next row to write
    logic [`CNT_W-1:0]        row;
    logic [`CNT_W-1:0]        next_row;
    logic [`CNT_W-1:0]        last_row;
    logic                     accept;
    logic                     fill_done;
    logic                     valid_ok;

    assign accept    = (state_q == tpu_ctrl_pkg::IDLE) && start_i && !busy_o;
    assign last_row  = n_q + `CNT_W'(`MUL_SIZE - 2);
    assign row       = (state_q == tpu_ctrl_pkg::FILL) ? '0 : cnt_q;
    assign next_row  = row + 1'b1;
    assign fill_done = (act_valid_i || cnt_q != '0) && cnt_q == `CNT_W'(`MUL_SIZE - 1);

    always_comb begin
        row_cmd.wr   = 1'b1;
        row_cmd.add  = (mode_q == tpu_ctrl_pkg::MODE_ACCUMULATE);
        row_cmd.addr = row;
        // lane j of row a holds vector a-j, so every mask is the last one moved up a lane
        row_cmd.mask = (cmd_q.mask << 1) | `MUL_SIZE'(row < n_q);
    end

    always_comb begin
        if (next_row < `CNT_W'(`MUL_SIZE - 1)) begin
            next_state = tpu_ctrl_pkg::PARTIAL_OUTPUT;
        end else if (next_row < n_q) begin
            next_state = tpu_ctrl_pkg::FULL_OUTPUT;
        end else begin
            next_state = tpu_ctrl_pkg::REVERSE_PARTIAL;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            n_q    <= vec_count_i;
            mode_q <= mode_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= tpu_ctrl_pkg::IDLE;
            cmd_q   <= '0;
            cnt_q   <= '0;
            busy_o  <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                tpu_ctrl_pkg::IDLE: begin
                    cmd_q <= '0;
                    if (done_o) begin
                        busy_o <= 1'b0;   // busy covers the done cycle too
                    end
                    if (accept) begin
                        busy_o  <= 1'b1;
                        cnt_q   <= '0;
                        state_q <= tpu_ctrl_pkg::FILL;
                    end
                end
                tpu_ctrl_pkg::FILL: begin
                    if (act_valid_i || cnt_q != '0) begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                    if (fill_done) begin
                        cmd_q   <= row_cmd;   // row 0 leaves the array next cycle
                        cnt_q   <= next_row;
                        state_q <= next_state;
                    end
                end
                tpu_ctrl_pkg::PARTIAL_OUTPUT,
                tpu_ctrl_pkg::FULL_OUTPUT,
                tpu_ctrl_pkg::REVERSE_PARTIAL: begin
                    if (row > last_row) begin
                        cmd_q   <= '0;
                        done_o  <= 1'b1;
                        state_q <= tpu_ctrl_pkg::IDLE;
                    end else begin
                        cmd_q   <= row_cmd;
                        cnt_q   <= next_row;
                        state_q <= next_state;
                    end
                end
                default: state_q <= tpu_ctrl_pkg::IDLE;
            endcase
        end
    end

    assign cmd_o = cmd_q;

    // vector k of the pass may only arrive k cycles after the first one, for k below N
    always_comb begin
        case (state_q)
            tpu_ctrl_pkg::FILL: valid_ok = cnt_q < n_q;
            tpu_ctrl_pkg::PARTIAL_OUTPUT,
            tpu_ctrl_pkg::FULL_OUTPUT,
            tpu_ctrl_pkg::REVERSE_PARTIAL: valid_ok = cnt_q + `CNT_W'(`MUL_SIZE - 1) < n_q;
            default: valid_ok = 1'b0;
        endcase
    end

    a_valid_window: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        act_valid_i |-> valid_ok);

    a_mask_nonempty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cmd_q.wr |-> |cmd_q.mask);

    a_start_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i |-> !busy_o)
        else $warning("start ignored while a pass is running");

endmodule

// File: logic/systolic_mac_array.sv
`timescale 1ns/1ps
`include "tpu_cfg.svh"

module systolic_mac_array (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    act_valid_i,
    input  tpu_data_pkg::act_vec_t  act_i,
    input  logic                    weight_we_i,
    input  logic [`CNT_W-1:0]       weight_row_i,
    input  tpu_data_pkg::act_vec_t  weight_data_i,
    output tpu_data_pkg::psum_vec_t psum_o
);

    localparam int ROW_W = (`MUL_SIZE > 1) ? $clog2(`MUL_SIZE) : 1;

    tpu_data_pkg::act_vec_t   weight_q [`MUL_SIZE];   // weight_q[i][j] sits in row i, column j
    tpu_data_pkg::psum_word_t psum_q   [`MUL_SIZE][`MUL_SIZE];
    tpu_data_pkg::act_vec_t   act_in;

    assign act_in = act_valid_i ? act_i : '0;   // a bubble travels as zeros and adds nothing

    always_ff @(posedge clk_i) begin
        if (weight_we_i && weight_row_i < `CNT_W'(`MUL_SIZE)) begin
            weight_q[weight_row_i[ROW_W-1:0]] <= weight_data_i;
        end
    end

    for (genvar i = 0; i < `MUL_SIZE; i++) begin : g_row
        // dly_q[k] is element i delayed by k+1 cycles
        // the first i stages skew the row, the rest step the value across the columns
        tpu_data_pkg::act_word_t dly_q [i+`MUL_SIZE-1];

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                for (int k = 0; k < i + `MUL_SIZE - 1; k++) begin
                    dly_q[k] <= '0;
                end
            end else begin
                dly_q[0] <= act_in[i];
                for (int k = 1; k < i + `MUL_SIZE - 1; k++) begin
                    dly_q[k] <= dly_q[k-1];
                end
            end
        end

        for (genvar j = 0; j < `MUL_SIZE; j++) begin : g_col
            tpu_data_pkg::act_word_t    act_x;     // element i of the vector now at this cell
            tpu_data_pkg::psum_word_t   psum_in;
            logic signed [2*`ACT_W-1:0] prod;

            if (i + j == 0) begin : g_head
                assign act_x = act_in[0];
            end else begin : g_tap
                assign act_x = dly_q[i+j-1];
            end

            if (i == 0) begin : g_first
                assign psum_in = '0;
            end else begin : g_chain
                assign psum_in = psum_q[i-1][j];   // the same vector's sum from the row above
            end

            assign prod = act_x * $signed(weight_q[i][j]);

            always_ff @(posedge clk_i) begin
                psum_q[i][j] <= psum_in + prod;   // prod sign-extends to the lane width
            end
        end
    end

    // lane j leaves the bottom row MUL_SIZE+j cycles after its vector entered
    for (genvar j = 0; j < `MUL_SIZE; j++) begin : g_out
        assign psum_o[j] = psum_q[`MUL_SIZE-1][j];
    end

endmodule

// File: logic/tpu_data_pkg.sv
`include "tpu_cfg.svh"

package tpu_data_pkg;

    typedef logic signed [`ACT_W-1:0] act_word_t;
    typedef logic signed [`ACC_W-1:0] psum_word_t;

    // lane j sits at index j
    typedef act_word_t [`MUL_SIZE-1:0] act_vec_t;

    // array output, accumulator row and read data share this layout
    typedef psum_word_t [`MUL_SIZE-1:0] psum_vec_t;

endpackage

// File: logic/tpu_ctrl_pkg.sv
`include "tpu_cfg.svh"

package tpu_ctrl_pkg;

    typedef enum logic {
        MODE_OVERWRITE  = 1'b0,
        MODE_ACCUMULATE = 1'b1
    } mac_mode_e;

    // sequence of one pass through the accumulator
    typedef enum logic [2:0] {
        IDLE,
        FILL,
        PARTIAL_OUTPUT,
        FULL_OUTPUT,
        REVERSE_PARTIAL
    } acc_state_e;

    typedef struct packed {
        logic                 wr;     // write the addressed row this cycle
        logic                 add;    // add to the stored lanes instead of replacing them
        logic [`CNT_W-1:0]    addr;
        logic [`MUL_SIZE-1:0] mask;   // one bit per lane
    } acc_cmd_t;

endpackage

// File: logic/tpu_cfg.svh
`ifndef TPU_CFG_SVH
`define TPU_CFG_SVH

// lanes per vector, also the number of weight rows in a tile
`define MUL_SIZE  4
// signed activation and weight width
`define ACT_W     8
`define ACC_W     24        // signed accumulator lane
`define ACC_DEPTH 64        // accumulator rows

// row and vector counters need to reach ACC_DEPTH
`define CNT_W     7

`endif
